//--- Makefile
# Verilator build and run for the ingress stage

VERILATOR ?= verilator
TOP       ?= tb_smartnic_app_igr
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- axi4s_full_pipe.sv
`timescale 1ns/1ps

module axi4s_full_pipe (
    input  logic                  core_clk,
    input  logic                  rst_n,

    input  smartnic_pkg::axi4s_t  in_data,
    input  logic                  in_valid,
    output logic                  in_ready,

    output smartnic_pkg::axi4s_t  out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    // Skid entry catches the beat in flight when the output stalls
    smartnic_pkg::axi4s_t skid_data;
    logic                 skid_valid;

    // Output register free to take a new beat
    logic load_out;
    logic in_xfer;

    assign load_out = out_ready || !out_valid;

    // Straight from a flop with no path back to out_ready
    assign in_ready = !skid_valid;

    assign in_xfer = in_valid && in_ready;

    // Occupancy
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_out) begin
            // Skid drains first and blocks the input while full
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_xfer) begin
            // Park the new beat behind a stalled output
            skid_valid <= 1'b1;
        end
    end

    // Beat storage
    always_ff @(posedge core_clk) begin
        if (load_out) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (!load_out && in_xfer) begin
            skid_data <= in_data;
        end
    end

    // Stalled output holds its beat
    a_out_stable : assert property (
        @(posedge core_clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    );

endmodule

//--- axi4s_intf_demux.sv
`timescale 1ns/1ps

module axi4s_intf_demux (
    input  logic                  core_clk,
    input  logic                  rst_n,

    // Requested output, sampled on a packet's first beat
    input  logic                  sel,

    input  smartnic_pkg::axi4s_t  in_data,
    input  logic                  in_valid,
    output logic                  in_ready,

    output smartnic_pkg::axi4s_t  out_data  [2],
    output logic                  out_valid [2],
    input  logic                  out_ready [2]
);

    // Inside a packet, first beat already accepted
    logic in_pkt;
    // Output chosen for the current packet
    logic sel_hold;
    // Output in use this cycle
    logic sel_cur;
    logic in_xfer;

    // Live select between packets, latched one within
    assign sel_cur = in_pkt ? sel_hold : sel;

    assign in_xfer = in_valid && in_ready;

    // Same beat offered to both sides
    assign out_data[0] = in_data;
    assign out_data[1] = in_data;

    // Only the chosen side sees valid
    assign out_valid[0] = in_valid && !sel_cur;
    assign out_valid[1] = in_valid && sel_cur;

    // Back-pressure from the chosen side only
    assign in_ready = sel_cur ? out_ready[1] : out_ready[0];

    // Packet tracking
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            sel_hold <= 1'b0;
        end else if (in_xfer) begin
            // Last beat closes the packet, any other keeps it open
            in_pkt   <= !in_data.tlast;
            sel_hold <= sel_cur;
        end
    end

    // Never offer a beat to both sides
    a_one_hot_valid : assert property (
        @(posedge core_clk) disable iff (!rst_n)
        !(out_valid[0] && out_valid[1])
    );

    // A packet that started on one side must not move to the other
    for (genvar k = 0; k < 2; k++) begin : g_hold
        a_no_split : assert property (
            @(posedge core_clk) disable iff (!rst_n)
            (out_valid[k] && out_ready[k] && !in_data.tlast) |=> !out_valid[1-k]
        );
    end

endmodule

//--- smartnic_app_igr.sv
`timescale 1ns/1ps

module smartnic_app_igr #(
    parameter int NUM_PORTS = 2
) (
    input  logic                    core_clk,
    input  logic                    rst_n,

    // Ingress streams
    input  smartnic_pkg::axi4s_t    in_data   [NUM_PORTS],
    input  logic                    in_valid  [NUM_PORTS],
    output logic                    in_ready  [NUM_PORTS],

    // Egress streams
    output smartnic_pkg::axi4s_t    out_data  [NUM_PORTS],
    output logic                    out_valid [NUM_PORTS],
    input  logic                    out_ready [NUM_PORTS],

    // Host streams
    output smartnic_pkg::axi4s_t    c2h_data  [NUM_PORTS],
    output logic                    c2h_valid [NUM_PORTS],
    input  logic                    c2h_ready [NUM_PORTS],

    // Register bus
    input  smartnic_pkg::reg_req_t  reg_req,
    output smartnic_pkg::reg_rsp_t  reg_rsp
);

    // Software override from config
    logic demux_sel;

    // Packet-done strobes into the counters
    logic pkt_out_done [NUM_PORTS];
    logic pkt_c2h_done [NUM_PORTS];

    smartnic_app_igr_reg_blk #(
        .NUM_PORTS    (NUM_PORTS)
    ) reg_blk_inst (
        .core_clk     (core_clk),
        .rst_n        (rst_n),
        .reg_req      (reg_req),
        .reg_rsp      (reg_rsp),
        .demux_sel    (demux_sel),
        .pkt_out_done (pkt_out_done),
        .pkt_c2h_done (pkt_c2h_done)
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        smartnic_pkg::port_t  in_tdest;
        logic                 port_sel;

        // Demux side 0 feeds out, side 1 feeds c2h
        smartnic_pkg::axi4s_t demux_data  [2];
        logic                 demux_valid [2];
        logic                 demux_ready [2];

        // VF0 traffic or global override goes to host
        assign in_tdest = in_data[i].tdest;
        assign port_sel = (in_tdest.encoded.typ == smartnic_pkg::VF0) || demux_sel;

        axi4s_intf_demux demux_inst (
            .core_clk  (core_clk),
            .rst_n     (rst_n),
            .sel       (port_sel),
            .in_data   (in_data[i]),
            .in_valid  (in_valid[i]),
            .in_ready  (in_ready[i]),
            .out_data  (demux_data),
            .out_valid (demux_valid),
            .out_ready (demux_ready)
        );

        axi4s_full_pipe out_pipe_inst (
            .core_clk  (core_clk),
            .rst_n     (rst_n),
            .in_data   (demux_data[0]),
            .in_valid  (demux_valid[0]),
            .in_ready  (demux_ready[0]),
            .out_data  (out_data[i]),
            .out_valid (out_valid[i]),
            .out_ready (out_ready[i])
        );

        axi4s_full_pipe c2h_pipe_inst (
            .core_clk  (core_clk),
            .rst_n     (rst_n),
            .in_data   (demux_data[1]),
            .in_valid  (demux_valid[1]),
            .in_ready  (demux_ready[1]),
            .out_data  (c2h_data[i]),
            .out_valid (c2h_valid[i]),
            .out_ready (c2h_ready[i])
        );

        // Count on the last beat leaving each pipe
        assign pkt_out_done[i] = out_valid[i] && out_ready[i] && out_data[i].tlast;
        assign pkt_c2h_done[i] = c2h_valid[i] && c2h_ready[i] && c2h_data[i].tlast;
    end

endmodule

//--- smartnic_app_igr_reg_blk.sv
`timescale 1ns/1ps

module smartnic_app_igr_reg_blk #(
    parameter int NUM_PORTS = 2
) (
    input  logic                    core_clk,
    input  logic                    rst_n,

    input  smartnic_pkg::reg_req_t  reg_req,
    output smartnic_pkg::reg_rsp_t  reg_rsp,

    // Software steering override
    output logic                    demux_sel,

    // One pulse per packet leaving each destination
    input  logic                    pkt_out_done [NUM_PORTS],
    input  logic                    pkt_c2h_done [NUM_PORTS]
);

    localparam int DW = smartnic_pkg::REG_DATA_WID;

    // Config bit 0
    logic cfg_demux_sel;

    // Packet counters, wrap at 2^32
    logic [DW-1:0] cnt_out [NUM_PORTS];
    logic [DW-1:0] cnt_c2h [NUM_PORTS];

    // Read path
    logic [DW-1:0] rd_data_nxt;
    logic [DW-1:0] rdata_q;
    logic          rd_ack_q;

    assign demux_sel = cfg_demux_sel;

    // Config write, takes effect at the strobe edge
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            cfg_demux_sel <= 1'b0;
        end else if (reg_req.wr && reg_req.addr == smartnic_pkg::REG_CONFIG) begin
            cfg_demux_sel <= reg_req.wdata[0];
        end
    end

    // Counters, read only from the bus side
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_cnt
        always_ff @(posedge core_clk) begin
            if (!rst_n) begin
                cnt_out[i] <= '0;
                cnt_c2h[i] <= '0;
            end else begin
                if (pkt_out_done[i]) begin
                    cnt_out[i] <= cnt_out[i] + 1'b1;
                end
                if (pkt_c2h_done[i]) begin
                    cnt_c2h[i] <= cnt_c2h[i] + 1'b1;
                end
            end
        end
    end

    // Address decode, unmapped reads as zero
    always_comb begin
        logic [smartnic_pkg::REG_ADDR_WID-1:0] base;
        rd_data_nxt = '0;
        if (reg_req.addr == smartnic_pkg::REG_CONFIG) begin
            rd_data_nxt = {{(DW-1){1'b0}}, cfg_demux_sel};
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            base = 8'(smartnic_pkg::REG_CNT_BASE + i * smartnic_pkg::REG_CNT_STRIDE);
            if (reg_req.addr == base) begin
                rd_data_nxt = cnt_out[i];
            end
            if (reg_req.addr == 8'(base + smartnic_pkg::REG_C2H_OFFSET)) begin
                rd_data_nxt = cnt_c2h[i];
            end
        end
    end

    // Ack one cycle after rd
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            rd_ack_q <= 1'b0;
        end else begin
            rd_ack_q <= reg_req.rd;
        end
    end

    // Read data captured with the strobe
    always_ff @(posedge core_clk) begin
        if (reg_req.rd) begin
            rdata_q <= rd_data_nxt;
        end
    end

    assign reg_rsp = '{rd_ack: rd_ack_q, rdata: rdata_q};

    // Bus master never issues both strobes at once
    a_wr_rd_excl : assert property (
        @(posedge core_clk) disable iff (!rst_n)
        !(reg_req.wr && reg_req.rd)
    );

endmodule

//--- smartnic_pkg.sv
package smartnic_pkg;

    // Stream beat geometry
    localparam int DATA_BYTE_WID = 8;
    localparam int DATA_WID      = DATA_BYTE_WID * 8;

    // Register bus geometry
    localparam int REG_ADDR_WID = 8;
    localparam int REG_DATA_WID = 32;

    // Destination port type, top two bits of tdest
    typedef enum logic [1:0] {
        PHY = 2'd0,
        PF  = 2'd1,
        VF0 = 2'd2,
        VF1 = 2'd3
    } port_typ_t;

    // Type and index view of a destination
    typedef struct packed {
        port_typ_t  typ;
        logic [1:0] num;
    } port_enc_t;

    // tdest seen either as a plain word or as type plus index
    typedef union packed {
        logic [3:0] raw;
        port_enc_t  encoded;
    } port_t;

    // One AXI4-Stream beat, 77 bits
    typedef struct packed {
        logic [DATA_WID-1:0]      tdata;
        logic [DATA_BYTE_WID-1:0] tkeep;
        logic                     tlast;
        port_t                    tdest;
    } axi4s_t;

    // Register request from the control side
    // wr and rd are single-cycle strobes
    typedef struct packed {
        logic                    wr;
        logic                    rd;
        logic [REG_ADDR_WID-1:0] addr;
        logic [REG_DATA_WID-1:0] wdata;
    } reg_req_t;

    // Read response, one cycle after rd
    typedef struct packed {
        logic                    rd_ack;
        logic [REG_DATA_WID-1:0] rdata;
    } reg_rsp_t;

    // Config register, bit 0 forces all traffic to c2h
    localparam logic [REG_ADDR_WID-1:0] REG_CONFIG = 8'h00;

    // Per-port counter pair starts here
    localparam logic [REG_ADDR_WID-1:0] REG_CNT_BASE = 8'h10;

    // Bytes between consecutive ports' counter pairs
    localparam logic [REG_ADDR_WID-1:0] REG_CNT_STRIDE = 8'h08;

    // c2h count sits above the out count
    localparam logic [REG_ADDR_WID-1:0] REG_C2H_OFFSET = 8'h04;

endpackage

//--- sources.f
smartnic_pkg.sv
axi4s_intf_demux.sv
axi4s_full_pipe.sv
smartnic_app_igr_reg_blk.sv
smartnic_app_igr.sv
tb_smartnic_app_igr.sv

//--- tb_smartnic_app_igr.sv
`timescale 1ns/1ps

module tb_smartnic_app_igr;

    localparam int NUM_PORTS  = 2;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_ROWS   = 16;

    // One packet per row, to_c2h is the expected destination
    typedef struct packed {
        logic [1:0] port;
        logic [3:0] tdest;
        logic [7:0] beats;
        logic       cfg;
        logic       mid_flip;
        logic       to_c2h;
    } row_t;

    logic core_clk = 1'b0;
    logic rst_n;

    smartnic_pkg::axi4s_t   in_data   [NUM_PORTS];
    logic                   in_valid  [NUM_PORTS];
    logic                   in_ready  [NUM_PORTS];
    smartnic_pkg::axi4s_t   out_data  [NUM_PORTS];
    logic                   out_valid [NUM_PORTS];
    logic                   out_ready [NUM_PORTS];
    smartnic_pkg::axi4s_t   c2h_data  [NUM_PORTS];
    logic                   c2h_valid [NUM_PORTS];
    logic                   c2h_ready [NUM_PORTS];
    smartnic_pkg::reg_req_t reg_req;
    smartnic_pkg::reg_rsp_t reg_rsp;

    // Scoreboard queues, index 0 is out and 1 is c2h
    smartnic_pkg::axi4s_t exp_q   [NUM_PORTS][2][$];
    int                   exp_cnt [NUM_PORTS][2];

    int          data_errs = 0;
    int          reg_errs  = 0;
    int          seq_errs  = 0;
    integer      seed      = 69;
    logic [31:0] beat_ctr  = '0;
    int          k;

    // port, tdest raw, beats, config, flip after beat 1, expected c2h
    // tdest[3:2] is the type, 0 PHY, 1 PF, 2 VF0, 3 VF1
    row_t rows [NUM_ROWS] = '{
        '{2'd0, 4'h1, 8'd3,  1'b0, 1'b0, 1'b0},
        '{2'd1, 4'h9, 8'd4,  1'b0, 1'b0, 1'b1},
        '{2'd0, 4'h8, 8'd1,  1'b0, 1'b0, 1'b1},
        '{2'd1, 4'h5, 8'd5,  1'b0, 1'b0, 1'b0},
        '{2'd0, 4'hE, 8'd6,  1'b0, 1'b0, 1'b0},
        '{2'd1, 4'hA, 8'd2,  1'b0, 1'b0, 1'b1},
        '{2'd0, 4'h2, 8'd4,  1'b1, 1'b0, 1'b1},
        '{2'd1, 4'hD, 8'd3,  1'b1, 1'b0, 1'b1},
        '{2'd0, 4'h6, 8'd5,  1'b0, 1'b1, 1'b0},
        '{2'd1, 4'h3, 8'd6,  1'b1, 1'b1, 1'b1},
        '{2'd0, 4'hB, 8'd8,  1'b0, 1'b0, 1'b1},
        '{2'd1, 4'hF, 8'd7,  1'b0, 1'b0, 1'b0},
        '{2'd0, 4'h0, 8'd12, 1'b0, 1'b0, 1'b0},
        '{2'd1, 4'h9, 8'd10, 1'b0, 1'b0, 1'b1},
        '{2'd0, 4'h7, 8'd9,  1'b1, 1'b0, 1'b1},
        '{2'd1, 4'hC, 8'd9,  1'b1, 1'b0, 1'b1}
    };

    smartnic_app_igr #(
        .NUM_PORTS (NUM_PORTS)
    ) dut (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .c2h_data  (c2h_data),
        .c2h_valid (c2h_valid),
        .c2h_ready (c2h_ready),
        .reg_req   (reg_req),
        .reg_rsp   (reg_rsp)
    );

    always #(CLK_PERIOD / 2) core_clk = ~core_clk;

    function automatic string dest_name(input int d);
        return (d != 0) ? "c2h" : "out";
    endfunction

    // Counter address from the register map
    function automatic logic [7:0] cnt_addr(input int p, input int d);
        return 8'(int'(smartnic_pkg::REG_CNT_BASE) + p * 8 + d * 4);
    endfunction

    // Row, beat index and counter stamped into the data
    function automatic smartnic_pkg::axi4s_t make_beat(input int r, input int b,
                                                       input logic [31:0] ctr);
        smartnic_pkg::axi4s_t beat;
        logic                 last;
        last           = (b == int'(rows[r].beats) - 1);
        beat.tdata     = {8'(r), 8'(b), ctr[15:0] ^ 16'hA5C3, ctr};
        beat.tkeep     = last ? (8'hFF >> (r % 8)) : 8'hFF;
        beat.tlast     = last;
        beat.tdest.raw = rows[r].tdest;
        return beat;
    endfunction

    // Neighbours on different ports with one config run together
    function automatic logic can_pair(input int r);
        if (r + 1 >= NUM_ROWS) begin
            return 1'b0;
        end
        return (rows[r].port != rows[r + 1].port) && (rows[r].cfg == rows[r + 1].cfg)
            && !rows[r].mid_flip && !rows[r + 1].mid_flip;
    endfunction

    function automatic logic all_drained();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p][0].size() != 0 || exp_q[p][1].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Called at a falling edge, returns at the next one
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        reg_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(negedge core_clk);
        reg_req.wr = 1'b0;
    endtask

    // Ack must be high for exactly the cycle after rd
    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
        reg_req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 32'd0};
        @(negedge core_clk);
        reg_req.rd = 1'b0;
        assert (reg_rsp.rd_ack) else begin
            reg_errs++;
            $display("No read acknowledge one cycle after rd to 0x%02h", addr);
        end
        assert (reg_rsp.rdata == exp) else begin
            reg_errs++;
            $display("[FAIL] %0t read 0x%02h returned %0d, expected %0d",
                     $time, addr, reg_rsp.rdata, exp);
        end
        @(negedge core_clk);
        assert (!reg_rsp.rd_ack) else begin
            reg_errs++;
            $display("Read acknowledge for 0x%02h held longer than one cycle", addr);
        end
    endtask

    // Ready sampled mid-cycle, beat moves at the next rising edge
    task automatic wait_accept(input int p);
        logic acc;
        do begin
            #1;
            acc = in_ready[p];
            @(posedge core_clk);
            if (!acc) begin
                @(negedge core_clk);
            end
        end while (!acc);
    endtask

    task automatic send_packet(input int r);
        int                   p;
        int                   d;
        smartnic_pkg::axi4s_t beat;
        p = int'(rows[r].port);
        d = int'(rows[r].to_c2h);
        exp_cnt[p][d]++;
        for (int b = 0; b < int'(rows[r].beats); b++) begin
            beat = make_beat(r, b, beat_ctr);
            beat_ctr++;
            exp_q[p][d].push_back(beat);
            @(negedge core_clk);
            in_data[p]  = beat;
            in_valid[p] = 1'b1;
            wait_accept(p);
            // Config flips while the demux sits inside the packet
            if (b == 0 && rows[r].mid_flip) begin
                @(negedge core_clk);
                in_valid[p] = 1'b0;
                write_reg(smartnic_pkg::REG_CONFIG, {31'd0, !rows[r].cfg});
            end
        end
        @(negedge core_clk);
        in_valid[p] = 1'b0;
    endtask

    task automatic check_beat(input int p, input int d, input smartnic_pkg::axi4s_t got);
        smartnic_pkg::axi4s_t exp;
        assert (exp_q[p][d].size() > 0) else begin
            seq_errs++;
            $display("Port %0d sent an unexpected beat to %s at %0t ns", p, dest_name(d), $time);
        end
        if (exp_q[p][d].size() > 0) begin
            exp = exp_q[p][d].pop_front();
            assert (got.tdata == exp.tdata) else begin
                data_errs++;
                $display("[FAIL] %0t port %0d %s tdata %h, expected %h",
                         $time, p, dest_name(d), got.tdata, exp.tdata);
            end
            assert (got.tkeep == exp.tkeep) else begin
                data_errs++;
                $display("[FAIL] %0t port %0d %s tkeep %h, expected %h",
                         $time, p, dest_name(d), got.tkeep, exp.tkeep);
            end
            assert (got.tlast == exp.tlast) else begin
                data_errs++;
                $display("[FAIL] %0t port %0d %s tlast %b, expected %b",
                         $time, p, dest_name(d), got.tlast, exp.tlast);
            end
            assert (got.tdest.raw == exp.tdest.raw) else begin
                data_errs++;
                $display("[FAIL] %0t port %0d %s tdest %h, expected %h",
                         $time, p, dest_name(d), got.tdest.raw, exp.tdest.raw);
            end
        end
    endtask

    // Random back-pressure and output monitors
    initial begin : monitor
        forever begin
            @(negedge core_clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                // Ready high about three cycles in four
                out_ready[p] = ($random(seed) & 3) != 0;
                c2h_ready[p] = ($random(seed) & 3) != 0;
            end
            #1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (out_valid[p] && out_ready[p]) begin
                    check_beat(p, 0, out_data[p]);
                end
                if (c2h_valid[p] && c2h_ready[p]) begin
                    check_beat(p, 1, c2h_data[p]);
                end
            end
        end
    end

    initial begin : watchdog
        int total_beats;
        total_beats = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_beats += int'(rows[r].beats);
        end
        #(total_beats * 20 * CLK_PERIOD + 2000);
        $display("Timeout: traffic for %0d beats did not finish in time", total_beats);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        reg_req = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_data[p]   = '0;
            in_valid[p]  = 1'b0;
            out_ready[p] = 1'b0;
            c2h_ready[p] = 1'b0;
            exp_cnt[p]   = '{0, 0};
        end
        repeat (8) @(posedge core_clk);
        @(negedge core_clk);
        rst_n = 1'b1;
        @(negedge core_clk);

        // Idle outputs, ready inputs, zeroed registers
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (!out_valid[p] && !c2h_valid[p]) else begin
                seq_errs++;
                $display("Port %0d has an output valid high after reset", p);
            end
            assert (in_ready[p]) else begin
                seq_errs++;
                $display("Port %0d input is not ready after reset", p);
            end
        end
        read_check(smartnic_pkg::REG_CONFIG, 32'd0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            read_check(cnt_addr(p, 0), 32'd0);
            read_check(cnt_addr(p, 1), 32'd0);
        end
        read_check(8'h40, 32'd0);

        k = 0;
        while (k < NUM_ROWS) begin
            write_reg(smartnic_pkg::REG_CONFIG, {31'd0, rows[k].cfg});
            if (can_pair(k)) begin
                fork
                    send_packet(k);
                    send_packet(k + 1);
                join
                k += 2;
            end else begin
                send_packet(k);
                k++;
            end
        end

        // Last beats still cross the output edge after the queues empty
        while (!all_drained()) begin
            @(negedge core_clk);
        end
        repeat (4) @(negedge core_clk);

        for (int p = 0; p < NUM_PORTS; p++) begin
            read_check(cnt_addr(p, 0), 32'(exp_cnt[p][0]));
            read_check(cnt_addr(p, 1), 32'(exp_cnt[p][1]));
        end
        read_check(cnt_addr(NUM_PORTS, 0), 32'd0);
        read_check(smartnic_pkg::REG_CONFIG, {31'd0, rows[NUM_ROWS - 1].cfg});

        $display("Errors: data %0d, register %0d, sequence %0d", data_errs, reg_errs, seq_errs);
        if (data_errs + reg_errs + seq_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
